// ==== flist.f ====
rtl/imul_pkg.sv
rtl/imul_ctrl.sv
rtl/imul_step_counter.sv
rtl/imul_dpath.sv
rtl/imul_iterative.sv
tests/imul_tb.sv

// ==== tests/imul_tb.sv ====
//--------------------------------------------------------------------------
// directed testbench for the iterative multiplier, one operation in flight
// outputs are sampled on the falling edge, inputs change on the rising edge
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module imul_tb;

  // wait limit in cycles for any handshake
  localparam int timeout_cyc = 100;
  // edges from the accepting edge, counting it, until resp_val is seen
  localparam int lat_edges   = 33;

  logic                clk;
  logic                reset;
  imul_pkg::mul_req_t  req;
  logic                req_val;
  logic                req_rdy;
  imul_pkg::mul_resp_t resp;
  logic                resp_val;
  logic                resp_rdy;

  int err_count;
  int check_count;

  // expected products for the back-to-back stream, in request order
  imul_pkg::mul_resp_t exp_q[$];

  imul_iterative dut0 (
    .clk      (clk),
    .reset    (reset),
    .req      (req),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp     (resp),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  //------------------------------------------------------------------------
  // compare helpers
  //------------------------------------------------------------------------

  task automatic check_resp(input imul_pkg::mul_resp_t got, input imul_pkg::mul_resp_t exp,
                            input string msg);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("mismatch at %0t: %s, got %h expected %h", $time, msg, got, exp);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string msg);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("mismatch at %0t: %s, got %b expected %b", $time, msg, got, exp);
    end
  endtask

  task automatic check_latency(input int got, input int exp, input string msg);
    check_count++;
    if (got != exp) begin
      err_count++;
      $display("mismatch at %0t: %s, got %0d expected %0d", $time, msg, got, exp);
    end
  endtask

  task automatic end_on_timeout(input string what);
    $display("timeout at %0t: %s", $time, what);
    $display("checks %0d, errors %0d", check_count, err_count + 1);
    $display("CHECKS FAILED");
    $finish;
  endtask

  //------------------------------------------------------------------------
  // reference model
  //------------------------------------------------------------------------

  // full 64-bit product from the operands as the opcode reads them
  task automatic ref_product(input imul_pkg::mul_req_t r, output imul_pkg::mul_resp_t p);
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    if (r.op == imul_pkg::mul_signed) begin
      sa = {{32{r.a[31]}}, r.a};
      sb = {{32{r.b[31]}}, r.b};
    end else begin
      sa = {32'b0, r.a};
      sb = {32'b0, r.b};
    end
    p.product = sa * sb;
  endtask

  function automatic imul_pkg::mul_req_t make_req(input imul_pkg::mul_op_e op,
                                                  input logic [31:0] a, input logic [31:0] b);
    imul_pkg::mul_req_t r;
    r.op = op;
    r.a  = a;
    r.b  = b;
    return r;
  endfunction

  //------------------------------------------------------------------------
  // handshake tasks
  //------------------------------------------------------------------------

  // returns at a falling edge with req_rdy high, next rising edge accepts
  task automatic wait_req_rdy();
    int n;
    n = 0;
    @(negedge clk);
    while (!req_rdy) begin
      n++;
      if (n > timeout_cyc) end_on_timeout("req_rdy never went high");
      @(negedge clk);
    end
  endtask

  // one full operation; hold is the number of extra cycles of back-pressure
  task automatic run_op(input imul_pkg::mul_req_t r, input int hold);
    imul_pkg::mul_resp_t exp;
    string               tag;
    int                  edges;
    ref_product(r, exp);
    tag = $sformatf("%s a %h b %h",
                    (r.op == imul_pkg::mul_signed) ? "signed" : "unsigned", r.a, r.b);
    @(posedge clk);
    req      <= r;
    req_val  <= 1'b1;
    resp_rdy <= 1'b0;
    wait_req_rdy();
    // accepting edge
    @(posedge clk);
    req_val <= 1'b0;
    edges = 1;
    @(negedge clk);
    while (!resp_val) begin
      check_bit(req_rdy, 1'b0, "req_rdy while busy");
      @(posedge clk);
      edges++;
      if (edges > lat_edges + timeout_cyc) end_on_timeout("resp_val never went high");
      @(negedge clk);
    end
    check_latency(edges, lat_edges, {"latency in edges, ", tag});
    check_resp(resp, exp, tag);
    // consumer stalls, product and flags must not move
    for (int i = 0; i < hold; i++) begin
      @(posedge clk);
      @(negedge clk);
      check_resp(resp, exp, {"held response, ", tag});
      check_bit(resp_val, 1'b1, "resp_val under back-pressure");
      check_bit(req_rdy, 1'b0, "req_rdy under back-pressure");
    end
    @(posedge clk);
    resp_rdy <= 1'b1;
    // taking edge
    @(posedge clk);
    resp_rdy <= 1'b0;
    @(negedge clk);
    check_bit(resp_val, 1'b0, "resp_val after take");
    check_bit(req_rdy, 1'b1, "req_rdy after take");
  endtask

  task automatic report_test(input string name, input int err_before);
    $display("test %s finished, %0d errors", name, err_count - err_before);
  endtask

  //------------------------------------------------------------------------
  // tests
  //------------------------------------------------------------------------

  task automatic test_reset_state();
    int e0;
    e0 = err_count;
    @(negedge clk);
    check_bit(req_rdy, 1'b1, "req_rdy after reset");
    check_bit(resp_val, 1'b0, "resp_val after reset");
    report_test("reset_state", e0);
  endtask

  task automatic test_unsigned_corners();
    int e0;
    e0 = err_count;
    run_op(make_req(imul_pkg::mul_unsigned, 32'h0, 32'h0), 0);
    run_op(make_req(imul_pkg::mul_unsigned, 32'h0, 32'hffff_ffff), 0);
    run_op(make_req(imul_pkg::mul_unsigned, 32'h1, 32'h1), 0);
    run_op(make_req(imul_pkg::mul_unsigned, 32'hffff_ffff, 32'h1), 0);
    run_op(make_req(imul_pkg::mul_unsigned, 32'hffff_ffff, 32'hffff_ffff), 0);
    // walking powers of two on both sides
    for (int k = 0; k < 32; k += 5) begin
      run_op(make_req(imul_pkg::mul_unsigned, 32'h1 << k, 32'h1 << (31 - k)), 0);
    end
    report_test("unsigned_corners", e0);
  endtask

  task automatic test_signed_corners();
    int e0;
    e0 = err_count;
    // every sign combination
    run_op(make_req(imul_pkg::mul_signed, 32'd7, 32'd3), 0);
    run_op(make_req(imul_pkg::mul_signed, -32'sd7, 32'd3), 0);
    run_op(make_req(imul_pkg::mul_signed, 32'd7, -32'sd3), 0);
    run_op(make_req(imul_pkg::mul_signed, -32'sd7, -32'sd3), 0);
    // most negative operand
    run_op(make_req(imul_pkg::mul_signed, 32'h8000_0000, 32'h8000_0000), 0);
    run_op(make_req(imul_pkg::mul_signed, 32'h8000_0000, 32'hffff_ffff), 0);
    run_op(make_req(imul_pkg::mul_signed, 32'h8000_0000, 32'h1), 0);
    run_op(make_req(imul_pkg::mul_signed, 32'hffff_ffff, 32'hffff_ffff), 0);
    report_test("signed_corners", e0);
  endtask

  task automatic test_random();
    int e0;
    e0 = err_count;
    for (int i = 0; i < 200; i++) begin
      run_op(make_req(imul_pkg::mul_op_e'($urandom_range(0, 1)), $urandom, $urandom), 0);
    end
    report_test("random", e0);
  endtask

  task automatic test_backpressure();
    int e0;
    e0 = err_count;
    for (int i = 0; i < 6; i++) begin
      run_op(make_req(imul_pkg::mul_op_e'($urandom_range(0, 1)), $urandom, $urandom),
             $urandom_range(1, 20));
    end
    // plain request right after the stalled ones
    run_op(make_req(imul_pkg::mul_signed, 32'h1234_5678, 32'hfedc_ba98), 0);
    report_test("backpressure", e0);
  endtask

  // producer keeps a request waiting while the consumer drains in order
  task automatic test_back_to_back();
    int                  e0;
    int                  n;
    imul_pkg::mul_req_t  r;
    imul_pkg::mul_resp_t exp;
    e0 = err_count;
    exp_q.delete();
    fork
      begin
        for (int i = 0; i < 8; i++) begin
          r = make_req(imul_pkg::mul_op_e'($urandom_range(0, 1)), $urandom, $urandom);
          @(posedge clk);
          req     <= r;
          req_val <= 1'b1;
          wait_req_rdy();
          @(posedge clk);
          ref_product(r, exp);
          exp_q.push_back(exp);
          req_val <= 1'b0;
        end
      end
      begin
        @(posedge clk);
        resp_rdy <= 1'b1;
        for (int i = 0; i < 8; i++) begin
          n = 0;
          @(negedge clk);
          while (!resp_val) begin
            n++;
            if (n > timeout_cyc) end_on_timeout("resp_val never went high in stream");
            @(negedge clk);
          end
          if (exp_q.size() == 0) begin
            err_count++;
            $display("error at %0t: response arrived with no request outstanding", $time);
          end else begin
            check_resp(resp, exp_q.pop_front(), $sformatf("stream response %0d", i));
          end
          // taking edge
          @(posedge clk);
        end
        resp_rdy <= 1'b0;
      end
    join
    report_test("back_to_back", e0);
  endtask

  //------------------------------------------------------------------------
  // main sequence
  //------------------------------------------------------------------------

  initial begin
    err_count   = 0;
    check_count = 0;
    reset       = 1'b1;
    req         = '0;
    req_val     = 1'b0;
    resp_rdy    = 1'b0;
    void'($urandom(5104));
    repeat (2) @(posedge clk);
    reset <= 1'b0;

    test_reset_state();
    test_unsigned_corners();
    test_signed_corners();
    test_random();
    test_backpressure();
    test_back_to_back();

    $display("checks %0d, errors %0d", check_count, err_count);
    if (err_count == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// ==== rtl/imul_iterative.sv ====
//--------------------------------------------------------------------------
// iterative 32-bit multiplier, one operation at a time, fixed latency
// valid/ready on both ports, request must stay steady while unaccepted
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module imul_iterative (
  input  logic                clk,
  input  logic                reset,

  // request port
  input  imul_pkg::mul_req_t  req,
  input  logic                req_val,
  output logic                req_rdy,

  // response port
  output imul_pkg::mul_resp_t resp,
  output logic                resp_val,
  input  logic                resp_rdy
);

  // strobes fan out to datapath and counter
  imul_pkg::dpath_ctrl_t ctrl;

  // final step flag back to the FSM
  logic                  last;

  //------------------------------------------------------------------------
  // control
  //------------------------------------------------------------------------

  imul_ctrl ctrl0 (
    .clk      (clk),
    .reset    (reset),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .last     (last),
    .ctrl     (ctrl)
  );

  // counts the 32 steps
  imul_step_counter cnt0 (
    .clk   (clk),
    .reset (reset),
    .ctrl  (ctrl),
    .last  (last)
  );

  //------------------------------------------------------------------------
  // datapath
  //------------------------------------------------------------------------

  // add decision uses the b bit locally, no status goes back
  imul_dpath dpath0 (
    .clk   (clk),
    .reset (reset),
    .req   (req),
    .ctrl  (ctrl),
    .resp  (resp)
  );

endmodule

// ==== rtl/imul_dpath.sv ====
//--------------------------------------------------------------------------
// shift-and-add datapath, works on magnitudes and fixes the sign at the end
// operands are sampled only on ctrl.load, the product is combinational
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module imul_dpath (
  input  logic                  clk,
  input  logic                  reset,

  // request message, valid on the accepting edge
  input  imul_pkg::mul_req_t    req,

  // strobes from the FSM
  input  imul_pkg::dpath_ctrl_t ctrl,

  // product with the sign applied
  output imul_pkg::mul_resp_t   resp
);

  localparam int op_w   = imul_pkg::op_w;
  localparam int prod_w = 2 * imul_pkg::op_w;

  //------------------------------------------------------------------------
  // operand unsigning
  //------------------------------------------------------------------------

  // signed op looks at the top bits, unsigned op never negates
  logic              is_signed;
  logic              a_neg;
  logic              b_neg;
  logic [op_w-1:0]   a_mag;
  logic [op_w-1:0]   b_mag;
  logic              neg_next;

  always_comb begin
    is_signed = (req.op == imul_pkg::mul_signed);
    a_neg     = is_signed & req.a[op_w-1];
    b_neg     = is_signed & req.b[op_w-1];

    // two's complement magnitude
    // the most negative value maps onto 2^31, still exact as unsigned
    a_mag = a_neg ? (~req.a + 1'b1) : req.a;
    b_mag = b_neg ? (~req.b + 1'b1) : req.b;

    // result is negative when exactly one operand is
    neg_next = a_neg ^ b_neg;
  end

  //------------------------------------------------------------------------
  // shift registers
  //------------------------------------------------------------------------

  // multiplicand, zero extended and moving left one place per step
  logic [prod_w-1:0] a_reg;

  // multiplier, consumed from the low end
  logic [op_w-1:0]   b_reg;

  always_ff @(posedge clk) begin
    if (ctrl.load) begin
      a_reg <= {{op_w{1'b0}}, a_mag};
    end else if (ctrl.step) begin
      a_reg <= a_reg << 1;
    end
  end

  always_ff @(posedge clk) begin
    if (ctrl.load) begin
      b_reg <= b_mag;
    end else if (ctrl.step) begin
      b_reg <= b_reg >> 1;
    end
  end

  //------------------------------------------------------------------------
  // accumulator
  //------------------------------------------------------------------------

  logic [prod_w-1:0] acc_reg;
  logic [prod_w-1:0] addend;
  logic [prod_w-1:0] acc_sum;

  // add the shifted multiplicand only for a set multiplier bit
  always_comb begin
    addend  = b_reg[0] ? a_reg : '0;
    acc_sum = acc_reg + addend;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      acc_reg <= '0;
    end else if (ctrl.load) begin
      // fresh operation starts from zero
      acc_reg <= '0;
    end else if (ctrl.step) begin
      acc_reg <= acc_sum;
    end
  end

  //------------------------------------------------------------------------
  // sign fix-up
  //------------------------------------------------------------------------

  logic              neg_reg;
  logic [prod_w-1:0] product;

  // saved at load time, the operands are gone by the end
  always_ff @(posedge clk) begin
    if (reset) begin
      neg_reg <= 1'b0;
    end else if (ctrl.load) begin
      neg_reg <= neg_next;
    end
  end

  // negate the unsigned product when the signs differed
  always_comb begin
    product = neg_reg ? (~acc_reg + 1'b1) : acc_reg;
  end

  // nothing moves in st_done, so this holds under back-pressure
  assign resp.product = product;

endmodule

// ==== rtl/imul_step_counter.sv ====
//--------------------------------------------------------------------------
// step counter for the shift-and-add loop, fixed latency
// last is a level and stays high while the count is zero
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module imul_step_counter (
  input  logic                  clk,
  input  logic                  reset,
  input  imul_pkg::dpath_ctrl_t ctrl,
  output logic                  last
);

  // one step per multiplier bit, so log2(op_w) bits of count
  localparam int cnt_w = $clog2(imul_pkg::op_w);

  // first step sees op_w-1, final step sees zero
  localparam logic [cnt_w-1:0] cnt_init = cnt_w'(imul_pkg::op_w - 1);

  logic [cnt_w-1:0] count_reg;

  //------------------------------------------------------------------------
  // count register
  //------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      count_reg <= '0;
    end else if (ctrl.count_load) begin
      count_reg <= cnt_init;
    end else if (ctrl.count_step) begin
      // wraps after the last step, harmless since the FSM has left calc
      count_reg <= count_reg - 1'b1;
    end
  end

  // zero count marks the final shift-and-add step
  assign last = (count_reg == '0);

endmodule

// ==== rtl/imul_ctrl.sv ====
//--------------------------------------------------------------------------
// control FSM for the iterative multiplier, one operation in flight
// outputs decode from the state, load strobes also follow req_val in idle
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module imul_ctrl (
  input  logic                  clk,
  input  logic                  reset,

  // request handshake
  input  logic                  req_val,
  output logic                  req_rdy,

  // response handshake
  output logic                  resp_val,
  input  logic                  resp_rdy,

  // high while the step counter sits at zero
  input  logic                  last,

  // datapath and counter strobes
  output imul_pkg::dpath_ctrl_t ctrl
);

  imul_pkg::ctrl_state_e state_reg;
  imul_pkg::ctrl_state_e state_next;

  // transfer happens when both sides agree
  logic req_go;
  logic resp_go;

  assign req_go  = req_val & req_rdy;
  assign resp_go = resp_val & resp_rdy;

  //------------------------------------------------------------------------
  // state register
  //------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state_reg <= imul_pkg::st_idle;
    end else begin
      state_reg <= state_next;
    end
  end

  //------------------------------------------------------------------------
  // next state
  //------------------------------------------------------------------------

  always_comb begin
    state_next = state_reg;
    case (state_reg)
      // wait for an operand pair
      imul_pkg::st_idle: begin
        if (req_go) begin
          state_next = imul_pkg::st_calc;
        end
      end
      // 32 shift-and-add steps, last marks the final one
      imul_pkg::st_calc: begin
        if (last) begin
          state_next = imul_pkg::st_done;
        end
      end
      // hold the product until the consumer takes it
      imul_pkg::st_done: begin
        if (resp_go) begin
          state_next = imul_pkg::st_idle;
        end
      end
      default: begin
        state_next = imul_pkg::st_idle;
      end
    endcase
  end

  //------------------------------------------------------------------------
  // output decode
  //------------------------------------------------------------------------

  // unused encoding keeps the all-low defaults
  always_comb begin
    req_rdy  = 1'b0;
    resp_val = 1'b0;
    ctrl     = '0;
    case (state_reg)
      imul_pkg::st_idle: begin
        req_rdy         = 1'b1;
        // capture operands and arm the counter on the accepting edge
        ctrl.load       = req_val;
        ctrl.count_load = req_val;
      end
      imul_pkg::st_calc: begin
        // one multiplier bit per cycle
        ctrl.step       = 1'b1;
        ctrl.count_step = 1'b1;
      end
      imul_pkg::st_done: begin
        // no strobes here so the product stays put under back-pressure
        resp_val        = 1'b1;
      end
    endcase
  end

endmodule

// ==== rtl/imul_pkg.sv ====
//--------------------------------------------------------------------------
// shared types for the iterative multiplier
// operand width is fixed at 32 and the product is twice as wide
//--------------------------------------------------------------------------

package imul_pkg;

  //------------------------------------------------------------------------
  // widths
  //------------------------------------------------------------------------

  localparam int op_w = 32;

  //------------------------------------------------------------------------
  // request and response messages
  //------------------------------------------------------------------------

  // operand interpretation
  typedef enum logic {
    mul_signed   = 1'b0,
    mul_unsigned = 1'b1
  } mul_op_e;

  // request message, 65 bits
  typedef struct packed {
    mul_op_e           op;
    logic [op_w-1:0]   a;
    logic [op_w-1:0]   b;
  } mul_req_t;

  // response message carries the full product
  typedef struct packed {
    logic [2*op_w-1:0] product;
  } mul_resp_t;

  //------------------------------------------------------------------------
  // control
  //------------------------------------------------------------------------

  typedef enum logic [1:0] {
    st_idle = 2'd0,
    st_calc = 2'd1,
    st_done = 2'd2
  } ctrl_state_e;

  // strobes from the FSM to the datapath and the step counter
  typedef struct packed {
    logic load;
    logic step;
    logic count_load;
    logic count_step;
  } dpath_ctrl_t;

endpackage
